/* cdc_pkg.sv */
package cdc_pkg;

    // ====================
    // Basic types
    // ====================

    typedef logic [7:0] byte_t;

    // ====================
    // Frame constants
    // ====================

    // Host to device frame header
    localparam byte_t RX_HDR_0 = 8'hAA;
    localparam byte_t RX_HDR_1 = 8'h55;

    // Device to host upload header
    localparam byte_t TX_HDR_0 = 8'hAA;
    localparam byte_t TX_HDR_1 = 8'h44;

    // Command codes
    localparam byte_t CMD_PWM_SET     = 8'h01;
    localparam byte_t CMD_METER_START = 8'h02;

    // Expected payload lengths of the two commands
    localparam logic [15:0] PWM_SET_LEN     = 16'd2;
    localparam logic [15:0] METER_START_LEN = 16'd3;

    // Upload framing
    localparam byte_t METER_SOURCE       = 8'h0A;
    localparam byte_t UPLOAD_LEN         = 8'd4;
    localparam int    UPLOAD_FRAME_BYTES = 9;

    // ====================
    // Datapath sizes
    // ====================

    localparam int NUM_PWM   = 8;
    localparam int NUM_DSM   = 8;
    localparam int PWM_SEL_W = $clog2(NUM_PWM);
    localparam int DSM_SEL_W = $clog2(NUM_DSM);

    // Requests below this are raised to it
    localparam logic [15:0] METER_MIN_WINDOW = 16'd16;

    // ====================
    // Bus structs
    // ====================

    typedef struct packed {
        logic        start;
        logic        data_valid;
        logic        done;
        byte_t       cmd_type;
        logic [15:0] length;
        logic [15:0] index;
        byte_t       data;
    } cmd_bus_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] high_count;
        logic [15:0] edge_count;
    } meter_result_t;

    // Checksum is the 8-bit wrapping sum of every byte between header and checksum
    function automatic byte_t csum_add(input byte_t acc, input byte_t value);
        return acc + value;
    endfunction

endpackage

/* command_dispatcher.sv */
module command_dispatcher (
    input  logic              clk,
    input  logic              rst_n,
    input  cdc_pkg::byte_t    usb_data,
    input  logic              usb_data_valid,
    output cdc_pkg::cmd_bus_t cmd_bus
);

    typedef enum logic [2:0] {
        ST_HDR0,
        ST_HDR1,
        ST_TYPE,
        ST_LEN_H,
        ST_LEN_L,
        ST_PAYLOAD,
        ST_CSUM
    } state_e;

    state_e         state;
    logic           valid_d;
    logic           byte_take;
    cdc_pkg::byte_t rx_type;
    cdc_pkg::byte_t len_h;
    logic [15:0]    frame_len;
    logic [15:0]    remaining;
    cdc_pkg::byte_t csum;
    cdc_pkg::byte_t csum_next;

    // ====================
    // Byte edge detection
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= usb_data_valid;
        end
    end

    // One byte per rising edge of the host valid
    assign byte_take = usb_data_valid & ~valid_d;

    assign frame_len = {len_h, usb_data};
    assign csum_next = cdc_pkg::csum_add(csum, usb_data);

    // ====================
    // Frame parser
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_HDR0;
            rx_type   <= '0;
            len_h     <= '0;
            remaining <= '0;
            csum      <= '0;
            cmd_bus   <= '0;
        end else begin
            // Strobes last one cycle
            cmd_bus.start      <= 1'b0;
            cmd_bus.data_valid <= 1'b0;
            cmd_bus.done       <= 1'b0;

            if (byte_take) begin
                case (state)
                    ST_HDR0: begin
                        if (usb_data == cdc_pkg::RX_HDR_0) begin
                            state <= ST_HDR1;
                        end
                    end
                    ST_HDR1: begin
                        // A repeated first header byte keeps us aligned
                        if (usb_data == cdc_pkg::RX_HDR_1) begin
                            state <= ST_TYPE;
                        end else if (usb_data != cdc_pkg::RX_HDR_0) begin
                            state <= ST_HDR0;
                        end
                    end
                    ST_TYPE: begin
                        rx_type <= usb_data;
                        csum    <= usb_data;
                        state   <= ST_LEN_H;
                    end
                    ST_LEN_H: begin
                        len_h <= usb_data;
                        csum  <= csum_next;
                        state <= ST_LEN_L;
                    end
                    ST_LEN_L: begin
                        csum             <= csum_next;
                        remaining        <= frame_len;
                        cmd_bus.start    <= 1'b1;
                        cmd_bus.cmd_type <= rx_type;
                        cmd_bus.length   <= frame_len;
                        // Empty payload skips straight to the checksum
                        state <= (frame_len == 16'd0) ? ST_CSUM : ST_PAYLOAD;
                    end
                    ST_PAYLOAD: begin
                        csum               <= csum_next;
                        cmd_bus.data_valid <= 1'b1;
                        cmd_bus.data       <= usb_data;
                        cmd_bus.index      <= cmd_bus.length - remaining;
                        remaining          <= remaining - 16'd1;
                        if (remaining == 16'd1) begin
                            state <= ST_CSUM;
                        end
                    end
                    ST_CSUM: begin
                        // Bad checksum just drops the frame
                        cmd_bus.done <= (usb_data == csum);
                        state        <= ST_HDR0;
                    end
                    default: begin
                        state <= ST_HDR0;
                    end
                endcase
            end
        end
    end

endmodule

/* pwm_bank.sv */
module pwm_bank (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cdc_pkg::cmd_bus_t             cmd_bus,
    output logic [cdc_pkg::NUM_PWM-1:0]   pwm_pins
);

    logic [7:0]                           cnt;
    logic [cdc_pkg::NUM_PWM-1:0][7:0]     duty;
    logic                                 own;
    logic                                 pending;
    logic [cdc_pkg::PWM_SEL_W-1:0]        stage_ch;
    cdc_pkg::byte_t                       stage_duty;
    logic [cdc_pkg::PWM_SEL_W-1:0]        pend_ch;
    cdc_pkg::byte_t                       pend_duty;

    // ====================
    // Control
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            duty    <= '0;
            own     <= 1'b0;
            pending <= 1'b0;
        end else begin
            cnt <= cnt + 8'd1;

            // Claim the command on start, by type and length
            if (cmd_bus.start) begin
                own <= (cmd_bus.cmd_type == cdc_pkg::CMD_PWM_SET) &&
                       (cmd_bus.length == cdc_pkg::PWM_SET_LEN);
            end

            // Duty changes only at the counter wrap, never mid period
            if (pending && cnt == 8'hFF) begin
                duty[pend_ch] <= pend_duty;
                pending       <= 1'b0;
            end

            if (cmd_bus.done && own) begin
                pending <= 1'b1;
            end
        end
    end

    // Staged bytes and the committed request
    always_ff @(posedge clk) begin
        if (cmd_bus.data_valid && own) begin
            if (cmd_bus.index == 16'd0) begin
                stage_ch <= cmd_bus.data[cdc_pkg::PWM_SEL_W-1:0];
            end
            if (cmd_bus.index == 16'd1) begin
                stage_duty <= cmd_bus.data;
            end
        end
        if (cmd_bus.done && own) begin
            pend_ch   <= stage_ch;
            pend_duty <= stage_duty;
        end
    end

    // High for duty cycles out of 256
    always_comb begin
        for (int i = 0; i < cdc_pkg::NUM_PWM; i++) begin
            pwm_pins[i] = (cnt < duty[i]);
        end
    end

endmodule

/* signal_meter.sv */
module signal_meter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cdc_pkg::cmd_bus_t             cmd_bus,
    input  logic [cdc_pkg::NUM_DSM-1:0]   dsm_signal,
    output cdc_pkg::meter_result_t        result
);

    logic [cdc_pkg::NUM_DSM-1:0]   sync1;
    logic [cdc_pkg::NUM_DSM-1:0]   sync2;
    logic                          own;
    logic                          running;
    logic                          res_valid;
    logic [cdc_pkg::DSM_SEL_W-1:0] stage_ch;
    logic [cdc_pkg::DSM_SEL_W-1:0] sel_ch;
    logic [15:0]                   stage_win;
    logic [15:0]                   eff_win;
    logic [15:0]                   remaining;
    logic [15:0]                   high_count;
    logic [15:0]                   edge_count;
    logic                          prev;
    logic                          cur;

    assign eff_win = (stage_win < cdc_pkg::METER_MIN_WINDOW) ?
                     cdc_pkg::METER_MIN_WINDOW : stage_win;
    assign cur     = sync2[sel_ch];

    // Channel and window bytes, window high byte first
    always_ff @(posedge clk) begin
        if (cmd_bus.data_valid && own) begin
            case (cmd_bus.index)
                16'd0:   stage_ch        <= cmd_bus.data[cdc_pkg::DSM_SEL_W-1:0];
                16'd1:   stage_win[15:8] <= cmd_bus.data;
                16'd2:   stage_win[7:0]  <= cmd_bus.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1      <= '0;
            sync2      <= '0;
            own        <= 1'b0;
            running    <= 1'b0;
            res_valid  <= 1'b0;
            sel_ch     <= '0;
            remaining  <= '0;
            high_count <= '0;
            edge_count <= '0;
            prev       <= 1'b0;
        end else begin
            sync1     <= dsm_signal;
            sync2     <= sync1;
            res_valid <= 1'b0;

            if (cmd_bus.start) begin
                own <= (cmd_bus.cmd_type == cdc_pkg::CMD_METER_START) &&
                       (cmd_bus.length == cdc_pkg::METER_START_LEN);
            end

            // ====================
            // Measurement window
            // ====================
            if (running) begin
                prev      <= cur;
                remaining <= remaining - 16'd1;
                if (cur && high_count != 16'hFFFF) begin
                    high_count <= high_count + 16'd1;
                end
                if (cur && !prev && edge_count != 16'hFFFF) begin
                    edge_count <= edge_count + 16'd1;
                end
                if (remaining == 16'd1) begin
                    running   <= 1'b0;
                    res_valid <= 1'b1;
                end
            end

            // A good new command restarts any window in progress
            if (cmd_bus.done && own) begin
                running    <= 1'b1;
                res_valid  <= 1'b0;
                sel_ch     <= stage_ch;
                remaining  <= eff_win;
                high_count <= '0;
                edge_count <= '0;
                prev       <= sync2[stage_ch];
            end
        end
    end

    assign result.valid      = res_valid;
    assign result.high_count = high_count;
    assign result.edge_count = edge_count;

endmodule

/* upload_framer.sv */
module upload_framer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cdc_pkg::meter_result_t result,
    output cdc_pkg::byte_t         usb_upload_data,
    output logic                   usb_upload_valid
);

    logic           active;
    logic [3:0]     step;
    cdc_pkg::byte_t csum;
    logic [15:0]    high_cap;
    logic [15:0]    edge_cap;

    // Counts are held for the whole frame
    always_ff @(posedge clk) begin
        if (result.valid) begin
            high_cap <= result.high_count;
            edge_cap <= result.edge_count;
        end
    end

    // ====================
    // Byte sequencer
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            step   <= '0;
            csum   <= '0;
        end else begin
            if (result.valid) begin
                active <= 1'b1;
                step   <= '0;
                csum   <= '0;
            end else if (active) begin
                step <= step + 4'd1;
                // Source, length and the four count bytes go into the sum
                if (step >= 4'd2 && step <= 4'd7) begin
                    csum <= cdc_pkg::csum_add(csum, usb_upload_data);
                end
                if (step == 4'(cdc_pkg::UPLOAD_FRAME_BYTES - 1)) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (step)
            4'd0:    usb_upload_data = cdc_pkg::TX_HDR_0;
            4'd1:    usb_upload_data = cdc_pkg::TX_HDR_1;
            4'd2:    usb_upload_data = cdc_pkg::METER_SOURCE;
            4'd3:    usb_upload_data = cdc_pkg::UPLOAD_LEN;
            4'd4:    usb_upload_data = high_cap[15:8];
            4'd5:    usb_upload_data = high_cap[7:0];
            4'd6:    usb_upload_data = edge_cap[15:8];
            4'd7:    usb_upload_data = edge_cap[7:0];
            default: usb_upload_data = csum;
        endcase
    end

    assign usb_upload_valid = active;

endmodule

/* cdc_top.sv */
module cdc_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cdc_pkg::byte_t                usb_data,
    input  logic                          usb_data_valid,
    input  logic [cdc_pkg::NUM_DSM-1:0]   dsm_signal,
    output logic [cdc_pkg::NUM_PWM-1:0]   pwm_pins,
    output cdc_pkg::byte_t                usb_upload_data,
    output logic                          usb_upload_valid
);

    cdc_pkg::cmd_bus_t      cmd_bus;
    cdc_pkg::meter_result_t meter_result;

    // Frame parser and command bus source
    command_dispatcher u_dispatcher (
        .clk            (clk),
        .rst_n          (rst_n),
        .usb_data       (usb_data),
        .usb_data_valid (usb_data_valid),
        .cmd_bus        (cmd_bus)
    );

    // ====================
    // Handlers
    // ====================

    pwm_bank u_pwm (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_bus  (cmd_bus),
        .pwm_pins (pwm_pins)
    );

    signal_meter u_meter (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_bus    (cmd_bus),
        .dsm_signal (dsm_signal),
        .result     (meter_result)
    );

    // Upload path back to the host
    upload_framer u_framer (
        .clk              (clk),
        .rst_n            (rst_n),
        .result           (meter_result),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid)
    );

endmodule

/* cdc_assert.sv */
module cdc_assert (
    input logic                   clk,
    input logic                   rst_n,
    input cdc_pkg::cmd_bus_t      cmd_bus,
    input cdc_pkg::meter_result_t result,
    input logic                   usb_upload_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // ====================
    // Upload stream
    // ====================

    // Each upload is one unbroken run of frame bytes
    upload_run_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(usb_upload_valid) |->
            usb_upload_valid [*cdc_pkg::UPLOAD_FRAME_BYTES] ##1 !usb_upload_valid)
        else $error("usb_upload_valid run length differs from the frame size");

    // No new result while a frame is still going out
    result_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        result.valid |-> !usb_upload_valid)
        else $error("result.valid arrived during an upload frame");

    // Command bus
    start_done_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd_bus.start && cmd_bus.done))
        else $error("cmd_bus start and done in the same cycle");

endmodule

bind cdc_top cdc_assert assert_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_bus          (cmd_bus),
    .result           (meter_result),
    .usb_upload_valid (usb_upload_valid)
);

/* cdc_tb.sv */
module cdc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;
    localparam int WAVE_PERIOD  = 8;
    localparam int WAVE_HIGH    = 3;
    localparam int FRAME_CYCLES = 22;
    localparam int UPLOAD_SLACK = 50;
    localparam int MAX_WINDOW   = 160;
    localparam int PWM_SETTLE   = 264;
    localparam int PWM_CHECK    = PWM_SETTLE + 256;
    // Sum of all test lengths, doubled
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 64 + 9 * FRAME_CYCLES + 8 +
                                          3 * (MAX_WINDOW + UPLOAD_SLACK) +
                                          16 + UPLOAD_SLACK + 3 * PWM_CHECK);

    logic                        clk;
    logic                        rst_n;
    cdc_pkg::byte_t              usb_data;
    logic                        usb_data_valid;
    logic [cdc_pkg::NUM_DSM-1:0] dsm_signal;
    logic [cdc_pkg::NUM_PWM-1:0] pwm_pins;
    cdc_pkg::byte_t              usb_upload_data;
    logic                        usb_upload_valid;

    integer         seed = 32'h994d_7bf9;
    int             errors;
    int             test_start_errors;
    int             tests_passed;
    int             tests_failed;
    int             model_duty [cdc_pkg::NUM_PWM] = '{default: 0};
    // 0 drives low, 1 drives the square wave, 2 holds the channel high
    int             wave_mode;
    int             wave_phase;
    int             meter_ch;
    logic [71:0]    expected_frame;
    logic           upload_armed;
    int             uploads_seen;
    int             rx_idx;
    cdc_pkg::byte_t exp_byte;

    cdc_top dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .usb_data         (usb_data),
        .usb_data_valid   (usb_data_valid),
        .dsm_signal       (dsm_signal),
        .pwm_pins         (pwm_pins),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Measured channel gets the wave, the others its inverse
    always @(posedge clk) begin
        #1;
        wave_phase = (wave_phase + 1) % WAVE_PERIOD;
        case (wave_mode)
            1:       dsm_signal = (wave_phase < WAVE_HIGH) ? (8'h01 << meter_ch) :
                                                             ~(8'h01 << meter_ch);
            2:       dsm_signal = 8'h01 << meter_ch;
            default: dsm_signal = '0;
        endcase
    end

    // ====================
    // Reference model
    // ====================

    function automatic logic [71:0] expected_upload(input int window, input bit held_high);
        int             win;
        logic [15:0]    high_cnt;
        logic [15:0]    edge_cnt;
        cdc_pkg::byte_t sum;
        win = (window < int'(cdc_pkg::METER_MIN_WINDOW)) ?
              int'(cdc_pkg::METER_MIN_WINDOW) : window;
        if (held_high) begin
            high_cnt = 16'(win);
            edge_cnt = 16'd0;
        end else begin
            high_cnt = 16'(win / WAVE_PERIOD * WAVE_HIGH);
            edge_cnt = 16'(win / WAVE_PERIOD);
        end
        sum = cdc_pkg::METER_SOURCE + cdc_pkg::UPLOAD_LEN + high_cnt[15:8] + high_cnt[7:0] +
              edge_cnt[15:8] + edge_cnt[7:0];
        return {cdc_pkg::TX_HDR_0, cdc_pkg::TX_HDR_1, cdc_pkg::METER_SOURCE,
                cdc_pkg::UPLOAD_LEN, high_cnt, edge_cnt, sum};
    endfunction

    // Upload monitor, sampled at the falling edge
    always @(negedge clk) begin
        if (rst_n && usb_upload_valid) begin
            if (!upload_armed) begin
                // Reported once, at the first byte of the stray frame
                assert (rx_idx != 0) else begin
                    $display("An upload frame arrived although none was expected");
                    errors++;
                end
            end else begin
                exp_byte = expected_frame[8 * (8 - rx_idx) +: 8];
                assert (usb_upload_data == exp_byte) else begin
                    $display("Error: usb_upload_data byte %0d expected 0x%02h actual 0x%02h",
                             rx_idx, exp_byte, usb_upload_data);
                    errors++;
                end
            end
            if (rx_idx == 8) begin
                rx_idx = 0;
                uploads_seen++;
                upload_armed = 1'b0;
            end else begin
                rx_idx++;
            end
        end
    end

    // ====================
    // Stimulus tasks
    // ====================

    task automatic drive_byte(input cdc_pkg::byte_t value);
        @(posedge clk);
        #1;
        usb_data       = value;
        usb_data_valid = 1'b1;
        @(posedge clk);
        #1;
        usb_data_valid = 1'b0;
    endtask

    task automatic send_frame(input cdc_pkg::byte_t cmd, input int len,
                              input cdc_pkg::byte_t b0, input cdc_pkg::byte_t b1,
                              input cdc_pkg::byte_t b2, input bit corrupt);
        cdc_pkg::byte_t payload [3];
        cdc_pkg::byte_t sum;
        payload[0] = b0;
        payload[1] = b1;
        payload[2] = b2;
        sum = cmd + 8'(len >> 8) + 8'(len);
        drive_byte(cdc_pkg::RX_HDR_0);
        drive_byte(cdc_pkg::RX_HDR_1);
        drive_byte(cmd);
        drive_byte(8'(len >> 8));
        drive_byte(8'(len));
        for (int i = 0; i < len; i++) begin
            drive_byte(payload[i]);
            sum = sum + payload[i];
        end
        // Every bit flipped so the frame is always rejected
        drive_byte(corrupt ? ~sum : sum);
    endtask

    task automatic check_pin_duties();
        int highs [cdc_pkg::NUM_PWM];
        repeat (PWM_SETTLE) @(posedge clk);
        for (int i = 0; i < cdc_pkg::NUM_PWM; i++) begin
            highs[i] = 0;
        end
        repeat (256) begin
            @(negedge clk);
            for (int i = 0; i < cdc_pkg::NUM_PWM; i++) begin
                highs[i] += pwm_pins[i];
            end
        end
        for (int i = 0; i < cdc_pkg::NUM_PWM; i++) begin
            assert (highs[i] == model_duty[i]) else begin
                $display("Error: pwm_pins[%0d] high cycles expected 0x%02h actual 0x%02h",
                         i, model_duty[i], highs[i]);
                errors++;
            end
        end
    endtask

    task automatic await_upload(input int limit);
        int start_count;
        int waited;
        start_count = uploads_seen;
        waited      = 0;
        while (uploads_seen == start_count && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        assert (uploads_seen != start_count) else begin
            $display("No upload frame arrived within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic check_no_upload(input int cycles);
        int start_count;
        start_count = uploads_seen;
        repeat (cycles) @(posedge clk);
        assert (uploads_seen == start_count) else begin
            $display("An upload frame was sent for a rejected frame");
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        int                          duty;
        int                          ch;
        int                          win;
        logic [cdc_pkg::NUM_PWM-1:0] pins_seen;
        logic                        upload_seen;
        rst_n             = 1'b0;
        usb_data          = '0;
        usb_data_valid    = 1'b0;
        dsm_signal        = '0;
        wave_mode         = 0;
        wave_phase        = 0;
        meter_ch          = 0;
        expected_frame    = '0;
        upload_armed      = 1'b0;
        uploads_seen      = 0;
        rx_idx            = 0;
        errors            = 0;
        test_start_errors = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        pins_seen   = '0;
        upload_seen = 1'b0;
        repeat (64) begin
            @(negedge clk);
            pins_seen   = pins_seen | pwm_pins;
            upload_seen = upload_seen | usb_upload_valid;
        end
        assert (pins_seen == '0) else begin
            $display("Error: pwm_pins expected 0x00 actual 0x%02h", pins_seen);
            errors++;
        end
        assert (!upload_seen) else begin
            $display("Error: usb_upload_valid expected 0x0 actual 0x1");
            errors++;
        end
        end_test("1 reset state");

        ch   = $random(seed) & 7;
        duty = $random(seed) & 255;
        send_frame(cdc_pkg::CMD_PWM_SET, 2, 8'(ch), 8'(duty), 8'h00, 1'b0);
        model_duty[ch] = duty;
        check_pin_duties();
        end_test("2 pwm set");

        meter_ch       = $random(seed) & 7;
        win            = (($random(seed) & 15) + 2) * WAVE_PERIOD;
        wave_mode      = 1;
        expected_frame = expected_upload(win, 1'b0);
        upload_armed   = 1'b1;
        send_frame(cdc_pkg::CMD_METER_START, 3, 8'(meter_ch), 8'(win >> 8), 8'(win), 1'b0);
        await_upload(win + UPLOAD_SLACK);
        end_test("3 square wave measurement");

        wave_mode      = 2;
        expected_frame = expected_upload(5, 1'b1);
        upload_armed   = 1'b1;
        send_frame(cdc_pkg::CMD_METER_START, 3, 8'(meter_ch), 8'h00, 8'd5, 1'b0);
        await_upload(int'(cdc_pkg::METER_MIN_WINDOW) + UPLOAD_SLACK);
        end_test("4 minimum window");

        wave_mode = 1;
        send_frame(cdc_pkg::CMD_PWM_SET, 2, 8'(ch), 8'(duty ^ 8'h5A), 8'h00, 1'b1);
        send_frame(cdc_pkg::CMD_METER_START, 3, 8'(meter_ch), 8'h00, 8'd64, 1'b1);
        // Unknown type at the lengths of both handlers
        send_frame(8'h07, 3, 8'(ch), 8'h00, 8'd64, 1'b0);
        send_frame(8'h07, 2, 8'(ch), 8'(duty ^ 8'hA5), 8'h00, 1'b0);
        check_no_upload(64 + UPLOAD_SLACK);
        check_pin_duties();
        end_test("5 rejected frames");

        // Stray bytes, one of them a lone first header byte
        drive_byte(8'h13);
        drive_byte(cdc_pkg::RX_HDR_0);
        drive_byte(8'h21);
        drive_byte(cdc_pkg::RX_HDR_1);
        ch             = $random(seed) & 7;
        duty           = $random(seed) & 255;
        meter_ch       = $random(seed) & 7;
        win            = (($random(seed) & 15) + 2) * WAVE_PERIOD;
        expected_frame = expected_upload(win, 1'b0);
        upload_armed   = 1'b1;
        send_frame(cdc_pkg::CMD_PWM_SET, 2, 8'(ch), 8'(duty), 8'h00, 1'b0);
        model_duty[ch] = duty;
        send_frame(cdc_pkg::CMD_METER_START, 3, 8'(meter_ch), 8'(win >> 8), 8'(win), 1'b0);
        await_upload(win + UPLOAD_SLACK);
        check_pin_duties();
        end_test("6 resync and back to back");

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* files.f */
cdc_pkg.sv
command_dispatcher.sv
pwm_bank.sv
signal_meter.sv
upload_framer.sv
cdc_top.sv
cdc_assert.sv
cdc_tb.sv

/* Bender.yml */
package:
  name: cdc

sources:
  - cdc_pkg.sv
  - command_dispatcher.sv
  - pwm_bank.sv
  - signal_meter.sv
  - upload_framer.sv
  - cdc_top.sv
  - target: simulation
    files:
      - cdc_assert.sv
      - cdc_tb.sv
